/* Bender.yml */
package:
  name: cpu16_pipe

sources:
  - include_dirs:
      - .
    files:
      - cpu_isa_pkg.sv
      - cpu_pipe_pkg.sv
      - cpu_regfile.sv
      - cpu_fetch_decode.sv
      - cpu_execute.sv
      - cpu_result.sv
      - cpu_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_cpu.sv

/* cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Data and instruction word width
`define CPU_XLEN 16

// Register file geometry
`define CPU_REG_W 3
`define CPU_NREGS 8

// Opcode field width, top bits of the instruction
`define CPU_OPC_W 5

// First fetch address after reset
`define CPU_RESET_PC 16'h0000

// Bubble encoding, opcode 00001 with zero operands
`define CPU_NOP_INSTR 16'h0800

`endif

/* cpu_execute.sv */
module cpu_execute (
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  mem_stall,
   input  logic                  halted,
   input  cpu_isa_pkg::opcode_e  id_opcode,
   input  cpu_isa_pkg::reg_idx_t id_rd,
   input  cpu_isa_pkg::word_t    id_imm,
   input  cpu_isa_pkg::word_t    id_pc_inc,
   input  cpu_isa_pkg::word_t    id_op_a,
   input  cpu_isa_pkg::word_t    id_op_b,
   input  cpu_isa_pkg::word_t    id_store_val,
   output cpu_isa_pkg::opcode_e  ex_opcode,
   output cpu_isa_pkg::reg_idx_t ex_rd,
   output logic                  ex_wr_en,
   output logic                  ex_is_load,
   output cpu_isa_pkg::word_t    ex_result,
   output cpu_isa_pkg::word_t    ex_store_val,
   output logic                  branch_taken,
   output cpu_isa_pkg::word_t    branch_target
);

   cpu_isa_pkg::opcode_e  op_q;
   cpu_isa_pkg::reg_idx_t rd_q;
   cpu_isa_pkg::word_t    imm_q;
   cpu_isa_pkg::word_t    pc_inc_q;
   cpu_isa_pkg::word_t    a_q;
   cpu_isa_pkg::word_t    b_q;
   cpu_isa_pkg::word_t    st_q;
   cpu_isa_pkg::alu_op_e  alu_op;
   cpu_isa_pkg::word_t    alu_out;
   logic                  hold;

   assign hold = mem_stall | halted;

   // Opcode is the control part of the decode/execute register
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         op_q <= cpu_isa_pkg::OPC_NOP;
      end else if (!hold) begin
         // Own branch squashes the instruction behind it
         op_q <= branch_taken ? cpu_isa_pkg::OPC_NOP : id_opcode;
      end
   end

   // Operands and immediates
   always_ff @(posedge clk) begin
      if (!hold) begin
         rd_q     <= id_rd;
         imm_q    <= id_imm;
         pc_inc_q <= id_pc_inc;
         a_q      <= id_op_a;
         b_q      <= id_op_b;
         st_q     <= id_store_val;
      end
   end

   // ALU operation and register write per opcode
   always_comb begin
      alu_op   = cpu_isa_pkg::ALU_ADD;
      ex_wr_en = 1'b0;
      case (op_q)
         cpu_isa_pkg::OPC_ADD, cpu_isa_pkg::OPC_ADDI, cpu_isa_pkg::OPC_LD: begin
            ex_wr_en = 1'b1;
         end
         cpu_isa_pkg::OPC_SUB: begin
            alu_op   = cpu_isa_pkg::ALU_SUB;
            ex_wr_en = 1'b1;
         end
         cpu_isa_pkg::OPC_AND: begin
            alu_op   = cpu_isa_pkg::ALU_AND;
            ex_wr_en = 1'b1;
         end
         cpu_isa_pkg::OPC_XOR: begin
            alu_op   = cpu_isa_pkg::ALU_XOR;
            ex_wr_en = 1'b1;
         end
         cpu_isa_pkg::OPC_LI: begin
            alu_op   = cpu_isa_pkg::ALU_PASS_B;
            ex_wr_en = 1'b1;
         end
         // ST uses the adder for its address only
         default: begin
         end
      endcase
   end

   always_comb begin
      case (alu_op)
         cpu_isa_pkg::ALU_SUB:    alu_out = a_q - b_q;
         cpu_isa_pkg::ALU_AND:    alu_out = a_q & b_q;
         cpu_isa_pkg::ALU_XOR:    alu_out = a_q ^ b_q;
         cpu_isa_pkg::ALU_PASS_B: alu_out = b_q;
         default:                 alu_out = a_q + b_q;
      endcase
   end

   // Branch test on rd value
   always_comb begin
      case (op_q)
         cpu_isa_pkg::OPC_BEQZ: branch_taken = (st_q == '0);
         cpu_isa_pkg::OPC_BNEZ: branch_taken = (st_q != '0);
         cpu_isa_pkg::OPC_J:    branch_taken = 1'b1;
         default:               branch_taken = 1'b0;
      endcase
   end

   // Offset counts half-words from PC + 2
   assign branch_target = pc_inc_q + {imm_q[$bits(imm_q)-2:0], 1'b0};

   assign ex_opcode    = op_q;
   assign ex_rd        = rd_q;
   assign ex_is_load   = (op_q == cpu_isa_pkg::OPC_LD);
   assign ex_result    = alu_out;
   assign ex_store_val = st_q;

endmodule

/* cpu_fetch_decode.sv */
`include "cpu_defs.svh"

module cpu_fetch_decode (
   input  logic                  clk,
   input  logic                  arst_n,
   output cpu_isa_pkg::word_t    imem_addr,
   input  cpu_isa_pkg::word_t    imem_data,
   input  logic                  branch_taken,
   input  cpu_isa_pkg::word_t    branch_target,
   input  cpu_isa_pkg::reg_idx_t ex_rd,
   input  logic                  ex_wr_en,
   input  logic                  ex_is_load,
   input  cpu_isa_pkg::word_t    ex_result,
   input  logic                  wb_en,
   input  cpu_isa_pkg::reg_idx_t wb_reg,
   input  cpu_isa_pkg::word_t    wb_data,
   input  logic                  mem_stall,
   input  logic                  halted,
   output cpu_isa_pkg::opcode_e  id_opcode,
   output cpu_isa_pkg::reg_idx_t id_rd,
   output cpu_isa_pkg::word_t    id_imm,
   output cpu_isa_pkg::word_t    id_pc_inc,
   output cpu_isa_pkg::word_t    id_op_a,
   output cpu_isa_pkg::word_t    id_op_b,
   output cpu_isa_pkg::word_t    id_store_val
);

   cpu_isa_pkg::word_t    pc;
   cpu_isa_pkg::word_t    pc_inc;
   cpu_isa_pkg::instr_t   ifid_instr;
   cpu_isa_pkg::word_t    ifid_raw;
   cpu_isa_pkg::word_t    ifid_pc_inc;
   cpu_isa_pkg::opcode_e  opcode;
   cpu_isa_pkg::reg_idx_t rs2_sel;
   cpu_isa_pkg::word_t    rf_rd1;
   cpu_isa_pkg::word_t    rf_rd2;
   cpu_isa_pkg::word_t    fwd_a;
   cpu_isa_pkg::word_t    fwd_b;
   cpu_isa_pkg::word_t    imm;
   logic                  r_type;
   logic                  uses_a;
   logic                  uses_b;
   logic                  lu_stall;
   logic                  hold;

   assign imem_addr = pc;
   assign pc_inc    = pc + `CPU_XLEN'd2;

   // Whole front end freezes on a memory wait or after HALT
   assign hold = mem_stall | halted;

   // PC and fetch/decode instruction
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pc         <= `CPU_RESET_PC;
         ifid_instr <= cpu_isa_pkg::instr_t'(`CPU_NOP_INSTR);
      end else if (!hold) begin
         if (branch_taken) begin
            // Squash the instruction being fetched and the one in decode
            pc         <= branch_target;
            ifid_instr <= cpu_isa_pkg::instr_t'(`CPU_NOP_INSTR);
         end else if (!lu_stall) begin
            pc         <= pc_inc;
            ifid_instr <= cpu_isa_pkg::instr_t'(imem_data);
         end
      end
   end

   // Return address travels with the instruction
   always_ff @(posedge clk) begin
      if (!hold && !branch_taken && !lu_stall) begin
         ifid_pc_inc <= pc_inc;
      end
   end

   assign ifid_raw = ifid_instr;
   assign opcode   = ifid_instr.opcode;

   // Immediate select and operand usage per opcode
   always_comb begin
      imm    = '0;
      r_type = 1'b0;
      uses_a = 1'b0;
      uses_b = 1'b0;
      case (opcode)
         cpu_isa_pkg::OPC_ADD, cpu_isa_pkg::OPC_SUB,
         cpu_isa_pkg::OPC_AND, cpu_isa_pkg::OPC_XOR: begin
            r_type = 1'b1;
            uses_a = 1'b1;
            uses_b = 1'b1;
         end
         cpu_isa_pkg::OPC_ADDI, cpu_isa_pkg::OPC_LD: begin
            uses_a = 1'b1;
            imm    = {{(`CPU_XLEN-5){ifid_raw[4]}}, ifid_raw[4:0]};
         end
         cpu_isa_pkg::OPC_ST: begin
            // Base in rs, store data in rd
            uses_a = 1'b1;
            uses_b = 1'b1;
            imm    = {{(`CPU_XLEN-5){ifid_raw[4]}}, ifid_raw[4:0]};
         end
         cpu_isa_pkg::OPC_LI: begin
            imm = {{(`CPU_XLEN-8){1'b0}}, ifid_raw[7:0]};
         end
         cpu_isa_pkg::OPC_BEQZ, cpu_isa_pkg::OPC_BNEZ: begin
            // Tested register is rd
            uses_b = 1'b1;
            imm    = {{(`CPU_XLEN-8){ifid_raw[7]}}, ifid_raw[7:0]};
         end
         cpu_isa_pkg::OPC_J: begin
            imm = {{(`CPU_XLEN-11){ifid_raw[10]}}, ifid_raw[10:0]};
         end
         default: begin
         end
      endcase
   end

   // Second read port: rt for register forms, rd otherwise
   assign rs2_sel = r_type ? ifid_instr.rt : ifid_instr.rd;

   cpu_regfile u_regfile (
      .clk      (clk),
      .arst_n   (arst_n),
      .rs1_sel  (ifid_instr.rs),
      .rs2_sel  (rs2_sel),
      .wr_sel   (wb_reg),
      .wr_en    (wb_en),
      .wr_data  (wb_data),
      .rs1_data (rf_rd1),
      .rs2_data (rf_rd2)
   );

   // Youngest producer wins: execute, then write-back, then file
   assign fwd_a = (ex_wr_en && ex_rd == ifid_instr.rs) ? ex_result :
                  (wb_en && wb_reg == ifid_instr.rs)   ? wb_data   :
                  rf_rd1;
   assign fwd_b = (ex_wr_en && ex_rd == rs2_sel) ? ex_result :
                  (wb_en && wb_reg == rs2_sel)   ? wb_data   :
                  rf_rd2;

   // Load result not ready until result stage
   assign lu_stall = ex_is_load &&
                     ((uses_a && ex_rd == ifid_instr.rs) || (uses_b && ex_rd == rs2_sel));

   // Bubble goes down while decode holds
   assign id_opcode    = lu_stall ? cpu_isa_pkg::OPC_NOP : opcode;
   assign id_rd        = ifid_instr.rd;
   assign id_imm       = imm;
   assign id_pc_inc    = ifid_pc_inc;
   assign id_op_a      = fwd_a;
   assign id_op_b      = r_type ? fwd_b : imm;
   assign id_store_val = fwd_b;

endmodule

/* cpu_isa_pkg.sv */
package cpu_isa_pkg;

   `include "cpu_defs.svh"

   // Data or address word
   typedef logic [`CPU_XLEN-1:0] word_t;

   // Register number
   typedef logic [`CPU_REG_W-1:0] reg_idx_t;

   // Opcodes, HALT at 0 and NOP at 1
   typedef enum logic [`CPU_OPC_W-1:0] {
      OPC_HALT = 5'b00000,
      OPC_NOP  = 5'b00001,
      OPC_J    = 5'b00100,
      OPC_ADDI = 5'b01000,
      OPC_BEQZ = 5'b01100,
      OPC_BNEZ = 5'b01101,
      OPC_ST   = 5'b10000,
      OPC_LD   = 5'b10001,
      OPC_LI   = 5'b11000,
      OPC_ADD  = 5'b11100,
      OPC_SUB  = 5'b11101,
      OPC_AND  = 5'b11110,
      OPC_XOR  = 5'b11111
   } opcode_e;

   // ALU operations
   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_XOR,
      ALU_PASS_B
   } alu_op_e;

   // Instruction fields, low two bits unused by register forms
   typedef struct packed {
      opcode_e    opcode;
      reg_idx_t   rd;
      reg_idx_t   rs;
      reg_idx_t   rt;
      logic [1:0] spare;
   } instr_t;

endpackage

/* cpu_pipe_pkg.sv */
package cpu_pipe_pkg;

   // APB master phases
   typedef enum logic [1:0] {
      APB_IDLE,
      APB_SETUP,
      APB_ACCESS
   } apb_state_e;

   // Write-back source
   typedef enum logic {
      RES_ALU,
      RES_LOAD
   } res_sel_e;

endpackage

/* cpu_regfile.sv */
`include "cpu_defs.svh"

module cpu_regfile (
   input  logic                  clk,
   input  logic                  arst_n,
   input  cpu_isa_pkg::reg_idx_t rs1_sel,
   input  cpu_isa_pkg::reg_idx_t rs2_sel,
   input  cpu_isa_pkg::reg_idx_t wr_sel,
   input  logic                  wr_en,
   input  cpu_isa_pkg::word_t    wr_data,
   output cpu_isa_pkg::word_t    rs1_data,
   output cpu_isa_pkg::word_t    rs2_data
);

   cpu_isa_pkg::word_t regs [`CPU_NREGS];

   // Single write port, registers start at zero
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < `CPU_NREGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wr_sel] <= wr_data;
      end
   end

   // Reads see the old value during a same-cycle write
   assign rs1_data = regs[rs1_sel];
   assign rs2_data = regs[rs2_sel];

endmodule

/* cpu_result.sv */
module cpu_result (
   input  logic                  clk,
   input  logic                  arst_n,
   input  cpu_isa_pkg::opcode_e  ex_opcode,
   input  cpu_isa_pkg::reg_idx_t ex_rd,
   input  logic                  ex_wr_en,
   input  cpu_isa_pkg::word_t    ex_result,
   input  cpu_isa_pkg::word_t    ex_store_val,
   output logic                  psel,
   output logic                  penable,
   output logic                  pwrite,
   output cpu_isa_pkg::word_t    paddr,
   output cpu_isa_pkg::word_t    pwdata,
   input  cpu_isa_pkg::word_t    prdata,
   input  logic                  pready,
   output logic                  mem_stall,
   output logic                  halted,
   output logic                  wb_en,
   output cpu_isa_pkg::reg_idx_t wb_reg,
   output cpu_isa_pkg::word_t    wb_data
);

   cpu_isa_pkg::opcode_e     res_opcode;
   logic                     res_wr_en;
   cpu_isa_pkg::reg_idx_t    res_rd;
   cpu_isa_pkg::word_t       res_result;
   cpu_isa_pkg::word_t       res_store_val;
   cpu_pipe_pkg::apb_state_e state;
   cpu_pipe_pkg::res_sel_e   res_sel;
   logic                     advance;
   logic                     ex_is_mem;

   assign ex_is_mem = (ex_opcode == cpu_isa_pkg::OPC_LD) ||
                      (ex_opcode == cpu_isa_pkg::OPC_ST);

   // Held through a transfer and frozen once halted
   assign advance = !mem_stall && !halted;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         res_opcode <= cpu_isa_pkg::OPC_NOP;
         res_wr_en  <= 1'b0;
      end else if (advance) begin
         res_opcode <= ex_opcode;
         res_wr_en  <= ex_wr_en;
      end
   end

   // Address, store data and destination
   always_ff @(posedge clk) begin
      if (advance) begin
         res_rd        <= ex_rd;
         res_result    <= ex_result;
         res_store_val <= ex_store_val;
      end
   end

   // SETUP is entered together with the LD or ST
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= cpu_pipe_pkg::APB_IDLE;
      end else begin
         case (state)
            cpu_pipe_pkg::APB_SETUP: begin
               state <= cpu_pipe_pkg::APB_ACCESS;
            end
            cpu_pipe_pkg::APB_ACCESS: begin
               if (pready) begin
                  // Back-to-back access goes straight to the next SETUP
                  state <= ex_is_mem ? cpu_pipe_pkg::APB_SETUP : cpu_pipe_pkg::APB_IDLE;
               end
            end
            default: begin
               if (advance && ex_is_mem) begin
                  state <= cpu_pipe_pkg::APB_SETUP;
               end
            end
         endcase
      end
   end

   assign psel    = (state != cpu_pipe_pkg::APB_IDLE);
   assign penable = (state == cpu_pipe_pkg::APB_ACCESS);
   assign pwrite  = (res_opcode == cpu_isa_pkg::OPC_ST);
   assign paddr   = res_result;
   assign pwdata  = res_store_val;

   // Earlier stages wait from SETUP until the slave is ready
   assign mem_stall = (state == cpu_pipe_pkg::APB_SETUP) ||
                      (state == cpu_pipe_pkg::APB_ACCESS && !pready);

   // Stays high until reset since the result register freezes on HALT
   assign halted = (res_opcode == cpu_isa_pkg::OPC_HALT);

   // Load data arrives with pready
   assign res_sel = (res_opcode == cpu_isa_pkg::OPC_LD) ? cpu_pipe_pkg::RES_LOAD :
                                                          cpu_pipe_pkg::RES_ALU;
   assign wb_data = (res_sel == cpu_pipe_pkg::RES_LOAD) ? prdata : res_result;
   assign wb_en   = res_wr_en && !mem_stall;
   assign wb_reg  = res_rd;

endmodule

/* cpu_top.sv */
module cpu_top (
   input  logic               clk,
   input  logic               arst_n,
   output cpu_isa_pkg::word_t imem_addr,
   input  cpu_isa_pkg::word_t imem_data,
   output logic               psel,
   output logic               penable,
   output logic               pwrite,
   output cpu_isa_pkg::word_t paddr,
   output cpu_isa_pkg::word_t pwdata,
   input  cpu_isa_pkg::word_t prdata,
   input  logic               pready,
   output logic               halted
);

   // Decode to execute
   cpu_isa_pkg::opcode_e  id_opcode;
   cpu_isa_pkg::reg_idx_t id_rd;
   cpu_isa_pkg::word_t    id_imm;
   cpu_isa_pkg::word_t    id_pc_inc;
   cpu_isa_pkg::word_t    id_op_a;
   cpu_isa_pkg::word_t    id_op_b;
   cpu_isa_pkg::word_t    id_store_val;

   // Execute to result, also forwarding and branch redirect
   cpu_isa_pkg::opcode_e  ex_opcode;
   cpu_isa_pkg::reg_idx_t ex_rd;
   logic                  ex_wr_en;
   logic                  ex_is_load;
   cpu_isa_pkg::word_t    ex_result;
   cpu_isa_pkg::word_t    ex_store_val;
   logic                  branch_taken;
   cpu_isa_pkg::word_t    branch_target;

   // Write-back and stall
   logic                  wb_en;
   cpu_isa_pkg::reg_idx_t wb_reg;
   cpu_isa_pkg::word_t    wb_data;
   logic                  mem_stall;

   cpu_fetch_decode u_fetch_decode (
      .clk           (clk),
      .arst_n        (arst_n),
      .imem_addr     (imem_addr),
      .imem_data     (imem_data),
      .branch_taken  (branch_taken),
      .branch_target (branch_target),
      .ex_rd         (ex_rd),
      .ex_wr_en      (ex_wr_en),
      .ex_is_load    (ex_is_load),
      .ex_result     (ex_result),
      .wb_en         (wb_en),
      .wb_reg        (wb_reg),
      .wb_data       (wb_data),
      .mem_stall     (mem_stall),
      .halted        (halted),
      .id_opcode     (id_opcode),
      .id_rd         (id_rd),
      .id_imm        (id_imm),
      .id_pc_inc     (id_pc_inc),
      .id_op_a       (id_op_a),
      .id_op_b       (id_op_b),
      .id_store_val  (id_store_val)
   );

   cpu_execute u_execute (
      .clk           (clk),
      .arst_n        (arst_n),
      .mem_stall     (mem_stall),
      .halted        (halted),
      .id_opcode     (id_opcode),
      .id_rd         (id_rd),
      .id_imm        (id_imm),
      .id_pc_inc     (id_pc_inc),
      .id_op_a       (id_op_a),
      .id_op_b       (id_op_b),
      .id_store_val  (id_store_val),
      .ex_opcode     (ex_opcode),
      .ex_rd         (ex_rd),
      .ex_wr_en      (ex_wr_en),
      .ex_is_load    (ex_is_load),
      .ex_result     (ex_result),
      .ex_store_val  (ex_store_val),
      .branch_taken  (branch_taken),
      .branch_target (branch_target)
   );

   cpu_result u_result (
      .clk          (clk),
      .arst_n       (arst_n),
      .ex_opcode    (ex_opcode),
      .ex_rd        (ex_rd),
      .ex_wr_en     (ex_wr_en),
      .ex_result    (ex_result),
      .ex_store_val (ex_store_val),
      .psel         (psel),
      .penable      (penable),
      .pwrite       (pwrite),
      .paddr        (paddr),
      .pwdata       (pwdata),
      .prdata       (prdata),
      .pready       (pready),
      .mem_stall    (mem_stall),
      .halted       (halted),
      .wb_en        (wb_en),
      .wb_reg       (wb_reg),
      .wb_data      (wb_data)
   );

endmodule

/* sim.f */
+incdir+.
cpu_isa_pkg.sv
cpu_pipe_pkg.sv
cpu_regfile.sv
cpu_fetch_decode.sv
cpu_execute.sv
cpu_result.sv
cpu_top.sv
tb_cpu.sv

/* tb_cpu.sv */
`include "cpu_defs.svh"

module tb_cpu;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int N_PROGS     = 40;
   localparam int MIN_BODY    = 30;
   localparam int MAX_BODY    = 60;
   localparam int PROG_DEPTH  = 128;
   localparam int TAIL_CYCLES = 20;
   // Longest program times generous cycles per instruction
   localparam int CYCLE_LIMIT = N_PROGS * MAX_BODY * 12;
   // R0 to R6 land here at the end of every program
   localparam cpu_isa_pkg::word_t DUMP_BASE = 16'h00e0;

   logic               clk;
   logic               arst_n;
   cpu_isa_pkg::word_t imem_addr;
   cpu_isa_pkg::word_t imem_data;
   logic               psel;
   logic               penable;
   logic               pwrite;
   cpu_isa_pkg::word_t paddr;
   cpu_isa_pkg::word_t pwdata;
   cpu_isa_pkg::word_t prdata;
   logic               pready;
   logic               halted;

   // Program ROM plus slave-side and model-side data memories
   cpu_isa_pkg::word_t prog [PROG_DEPTH];
   cpu_isa_pkg::word_t slave_mem [cpu_isa_pkg::word_t];
   cpu_isa_pkg::word_t model_mem [cpu_isa_pkg::word_t];
   cpu_isa_pkg::word_t mem_salt;

   // Expected APB transfers in program order
   logic               exp_write [$];
   cpu_isa_pkg::word_t exp_addr [$];
   cpu_isa_pkg::word_t exp_data [$];

   integer             seed;
   int                 cycle_count;
   int                 waits_left;
   logic               cur_write;
   cpu_isa_pkg::word_t cur_data;
   logic               prev_psel;
   logic               prev_penable;
   logic               prev_pready;
   logic               prev_pwrite;
   cpu_isa_pkg::word_t prev_paddr;
   cpu_isa_pkg::word_t prev_pwdata;

   cpu_top UUT (
      .clk       (clk),
      .arst_n    (arst_n),
      .imem_addr (imem_addr),
      .imem_data (imem_data),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .paddr     (paddr),
      .pwdata    (pwdata),
      .prdata    (prdata),
      .pready    (pready),
      .halted    (halted)
   );

   // Combinational ROM returning NOP outside the program window
   assign imem_data = (imem_addr[15:8] == 8'h00) ? prog[imem_addr[7:1]] : `CPU_NOP_INSTR;

   always #50 clk = ~clk;

   function automatic int rand_below(int n);
      return int'($unsigned($random(seed)) % n);
   endfunction

   // Half the time reuse the last destination for dense hazards
   function automatic int near_src(int last_rd);
      if (rand_below(2) == 0) begin
         return last_rd;
      end
      return rand_below(8);
   endfunction

   // Initial contents mixed from every address bit
   function automatic cpu_isa_pkg::word_t mem_fill(cpu_isa_pkg::word_t a);
      return (a * 16'h9e37) ^ {a[7:0], a[15:8]} ^ mem_salt;
   endfunction

   function automatic cpu_isa_pkg::word_t model_read(cpu_isa_pkg::word_t a);
      if (model_mem.exists(a)) begin
         return model_mem[a];
      end
      return mem_fill(a);
   endfunction

   function automatic cpu_isa_pkg::word_t slave_read(cpu_isa_pkg::word_t a);
      if (slave_mem.exists(a)) begin
         return slave_mem[a];
      end
      return mem_fill(a);
   endfunction

   function automatic cpu_isa_pkg::word_t sign_ext(cpu_isa_pkg::word_t v, int bits);
      cpu_isa_pkg::word_t shifted;
      shifted = v << (`CPU_XLEN - bits);
      return cpu_isa_pkg::word_t'($signed(shifted) >>> (`CPU_XLEN - bits));
   endfunction

   // Instruction encoders with the opcode in the top five bits
   function automatic cpu_isa_pkg::word_t enc_reg(cpu_isa_pkg::opcode_e op, int rd, int rs,
                                                  int rt);
      return {op, 3'(rd), 3'(rs), 3'(rt), 2'b00};
   endfunction

   function automatic cpu_isa_pkg::word_t enc_imm5(cpu_isa_pkg::opcode_e op, int rd, int rs,
                                                   int imm);
      return {op, 3'(rd), 3'(rs), 5'(imm)};
   endfunction

   function automatic cpu_isa_pkg::word_t enc_imm8(cpu_isa_pkg::opcode_e op, int rd, int imm);
      return {op, 3'(rd), 8'(imm)};
   endfunction

   task automatic fail_run;
      $display("Done: errors found");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic check_word(string name, cpu_isa_pkg::word_t got, cpu_isa_pkg::word_t exp);
      if (got !== exp) begin
         $display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp);
         fail_run();
      end
   endtask

   task automatic check_flag(string name, logic got, logic exp);
      if (got !== exp) begin
         $display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp);
         fail_run();
      end
   endtask

   // Random body with forward branches only followed by register dump and HALT
   task automatic build_program;
      int body_len;
      int last_rd;
      int pick;
      int rd;
      int src_a;
      int src_b;
      int max_off;
      int idx;
      for (int i = 0; i < PROG_DEPTH; i++) begin
         prog[i] = `CPU_NOP_INSTR;
      end
      body_len = MIN_BODY + rand_below(MAX_BODY - MIN_BODY + 1);
      last_rd  = 0;
      for (int i = 0; i < body_len; i++) begin
         pick  = rand_below(16);
         rd    = rand_below(8);
         src_a = near_src(last_rd);
         src_b = near_src(last_rd);
         // Target may be the first dump instruction at most
         max_off = body_len - 1 - i;
         if (max_off > 8) begin
            max_off = 8;
         end
         case (pick)
            0, 1:    prog[i] = enc_reg(cpu_isa_pkg::OPC_ADD, rd, src_a, src_b);
            2:       prog[i] = enc_reg(cpu_isa_pkg::OPC_SUB, rd, src_a, src_b);
            3:       prog[i] = enc_reg(cpu_isa_pkg::OPC_AND, rd, src_a, src_b);
            4:       prog[i] = enc_reg(cpu_isa_pkg::OPC_XOR, rd, src_a, src_b);
            5, 6:    prog[i] = enc_imm5(cpu_isa_pkg::OPC_ADDI, rd, src_a, rand_below(32));
            7, 8:    prog[i] = enc_imm8(cpu_isa_pkg::OPC_LI, rd,
                                        (rand_below(4) == 0) ? 0 : rand_below(256));
            9, 10:   prog[i] = enc_imm5(cpu_isa_pkg::OPC_LD, rd, src_a, rand_below(32));
            11:      prog[i] = enc_imm5(cpu_isa_pkg::OPC_ST, src_a, src_b, rand_below(32));
            12:      prog[i] = enc_imm8(cpu_isa_pkg::OPC_BEQZ, src_a, rand_below(max_off + 1));
            13:      prog[i] = enc_imm8(cpu_isa_pkg::OPC_BNEZ, src_a, rand_below(max_off + 1));
            14:      prog[i] = {cpu_isa_pkg::OPC_J, 11'(rand_below(max_off + 1))};
            default: prog[i] = `CPU_NOP_INSTR;
         endcase
         if (pick <= 10) begin
            last_rd = rd;
         end
      end
      // R7 goes out at its own address and then becomes the dump base
      idx = body_len;
      prog[idx] = enc_imm5(cpu_isa_pkg::OPC_ST, 7, 7, 0);
      idx++;
      prog[idx] = enc_imm8(cpu_isa_pkg::OPC_LI, 7, DUMP_BASE[7:0]);
      idx++;
      for (int k = 0; k < 7; k++) begin
         prog[idx] = enc_imm5(cpu_isa_pkg::OPC_ST, k, 7, 2 * k);
         idx++;
      end
      prog[idx] = {cpu_isa_pkg::OPC_HALT, 11'd0};
   endtask

   // ISA-level interpreter filling the expected transfer queues
   task automatic run_model;
      cpu_isa_pkg::word_t   regs [8];
      cpu_isa_pkg::word_t   pc;
      cpu_isa_pkg::word_t   ins;
      cpu_isa_pkg::word_t   addr;
      cpu_isa_pkg::opcode_e op;
      int                   rd;
      int                   rs;
      int                   rt;
      logic                 done;
      for (int i = 0; i < 8; i++) begin
         regs[i] = '0;
      end
      model_mem.delete();
      exp_write.delete();
      exp_addr.delete();
      exp_data.delete();
      pc   = `CPU_RESET_PC;
      done = 1'b0;
      while (!done) begin
         ins  = prog[pc[7:1]];
         op   = cpu_isa_pkg::opcode_e'(ins[15:11]);
         rd   = ins[10:8];
         rs   = ins[7:5];
         rt   = ins[4:2];
         addr = regs[rs] + sign_ext(ins, 5);
         pc   = pc + 16'd2;
         case (op)
            cpu_isa_pkg::OPC_ADD:  regs[rd] = regs[rs] + regs[rt];
            cpu_isa_pkg::OPC_SUB:  regs[rd] = regs[rs] - regs[rt];
            cpu_isa_pkg::OPC_AND:  regs[rd] = regs[rs] & regs[rt];
            cpu_isa_pkg::OPC_XOR:  regs[rd] = regs[rs] ^ regs[rt];
            cpu_isa_pkg::OPC_ADDI: regs[rd] = addr;
            cpu_isa_pkg::OPC_LI:   regs[rd] = {8'h00, ins[7:0]};
            cpu_isa_pkg::OPC_LD: begin
               regs[rd] = model_read(addr);
               exp_write.push_back(1'b0);
               exp_addr.push_back(addr);
               exp_data.push_back(regs[rd]);
            end
            cpu_isa_pkg::OPC_ST: begin
               model_mem[addr] = regs[rd];
               exp_write.push_back(1'b1);
               exp_addr.push_back(addr);
               exp_data.push_back(regs[rd]);
            end
            cpu_isa_pkg::OPC_BEQZ: begin
               if (regs[rd] == '0) begin
                  pc = pc + (sign_ext(ins, 8) << 1);
               end
            end
            cpu_isa_pkg::OPC_BNEZ: begin
               if (regs[rd] != '0) begin
                  pc = pc + (sign_ext(ins, 8) << 1);
               end
            end
            cpu_isa_pkg::OPC_J:    pc = pc + (sign_ext(ins, 11) << 1);
            cpu_isa_pkg::OPC_HALT: done = 1'b1;
            default: begin
            end
         endcase
      end
   endtask

   // APB slave and protocol monitor called once per cycle
   task automatic apb_step;
      cpu_isa_pkg::word_t rdata;
      logic               ready;
      ready = 1'b0;
      // Junk on prdata unless a read completes
      rdata = cpu_isa_pkg::word_t'($random(seed));
      if (!psel) begin
         check_flag("penable", penable, 1'b0);
      end else if (!penable) begin
         if (prev_psel && (!prev_penable || !prev_pready)) begin
            $display("APB error: SETUP phase while the previous transfer was still open");
            fail_run();
         end
         if (exp_addr.size() == 0) begin
            $display("APB error: transfer started that the program never issues");
            fail_run();
         end
         check_flag("halted", halted, 1'b0);
         cur_write = exp_write.pop_front();
         cur_data  = exp_data.pop_front();
         check_flag("pwrite", pwrite, cur_write);
         check_word("paddr", paddr, exp_addr.pop_front());
         if (cur_write) begin
            check_word("pwdata", pwdata, cur_data);
         end
         waits_left = rand_below(4);
      end else begin
         if (!prev_psel || (prev_penable && prev_pready)) begin
            $display("APB error: ACCESS phase without a SETUP phase");
            fail_run();
         end
         // Held stable across the whole transfer
         check_word("paddr", paddr, prev_paddr);
         check_flag("pwrite", pwrite, prev_pwrite);
         if (pwrite) begin
            check_word("pwdata", pwdata, prev_pwdata);
         end
         if (waits_left > 0) begin
            waits_left--;
         end else begin
            ready = 1'b1;
            if (pwrite) begin
               slave_mem[paddr] = pwdata;
            end else begin
               rdata = slave_read(paddr);
            end
         end
      end
      prev_psel    = psel;
      prev_penable = penable;
      prev_pready  = ready;
      prev_pwrite  = pwrite;
      prev_paddr   = paddr;
      prev_pwdata  = pwdata;
      pready       = ready;
      prdata       = rdata;
   endtask

   // Outputs settled and inputs driven 5 ns after the edge
   task automatic run_cycle;
      @(posedge clk);
      #5;
      cycle_count++;
      if (cycle_count > CYCLE_LIMIT) begin
         $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
         fail_run();
      end else begin
         apb_step();
      end
   endtask

   task automatic apply_reset;
      arst_n = 1'b0;
      repeat (5) begin
         run_cycle();
         check_flag("halted", halted, 1'b0);
         check_flag("psel", psel, 1'b0);
      end
      arst_n = 1'b1;
   endtask

   initial begin
      seed         = 32'h6ad9_d543;
      clk          = 1'b0;
      arst_n       = 1'b0;
      pready       = 1'b0;
      prdata       = '0;
      mem_salt     = '0;
      cycle_count  = 0;
      waits_left   = 0;
      cur_write    = 1'b0;
      cur_data     = '0;
      prev_psel    = 1'b0;
      prev_penable = 1'b0;
      prev_pready  = 1'b0;
      prev_pwrite  = 1'b0;
      prev_paddr   = '0;
      prev_pwdata  = '0;
      for (int p = 0; p < N_PROGS; p++) begin
         // Core is frozen or in reset while the ROM changes
         build_program();
         mem_salt = cpu_isa_pkg::word_t'($random(seed));
         slave_mem.delete();
         run_model();
         apply_reset();
         while (halted !== 1'b1) begin
            run_cycle();
         end
         if (exp_addr.size() != 0) begin
            $display("Error: halted with %0d expected APB transfers not seen", exp_addr.size());
            fail_run();
         end
         // Frozen core shows no further bus activity
         repeat (TAIL_CYCLES) begin
            run_cycle();
            check_flag("halted", halted, 1'b1);
            check_flag("psel", psel, 1'b0);
         end
      end
      $display("Done: no errors");
      $finish;
   end

endmodule
